//--- hdl/mem_req_pkg.sv
package mem_req_pkg;

// ################################################
// bus widths and response codes
// ################################################
localparam int ADDR_W = 32;
localparam int DATA_W = 32;

localparam logic [1:0] RESP_OKAY   = 2'b00;
localparam logic [1:0] RESP_SLVERR = 2'b10;

// ################################################
// request path payloads
// ################################################
typedef struct packed {
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;
} wr_req_t;

typedef struct packed {
	logic              wr;	// 0 for read-miss
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;	// zero on reads
} req_t;

typedef struct packed {
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;
	logic              err;
} rsp_t;

// ################################################
// axi4-lite channels
// ################################################
typedef struct packed {
	logic                aw_valid;
	logic [ADDR_W-1:0]   aw_addr;
	logic                w_valid;
	logic [DATA_W-1:0]   w_data;
	logic [DATA_W/8-1:0] w_strb;
	logic                b_ready;
	logic                ar_valid;
	logic [ADDR_W-1:0]   ar_addr;
	logic                r_ready;
} axil_req_t;

typedef struct packed {
	logic              aw_ready;
	logic              w_ready;
	logic              b_valid;
	logic [1:0]        b_resp;
	logic              ar_ready;
	logic              r_valid;
	logic [DATA_W-1:0] r_data;
	logic [1:0]        r_resp;
} axil_rsp_t;

typedef enum logic [1:0] {
	IDLE,
	GRANT_WR,
	GRANT_RD
} arb_state_t;

endpackage

//--- hdl/req_fifo.sv
`timescale 1ns/1ns

module req_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     push_i,
	input  payload_t data_i,
	output logic     full_o,

	input  logic     pop_i,
	output payload_t data_o,
	output logic     avail_o
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

payload_t		mem [DEPTH];
logic [PTR_W-1:0]	wr_ptr, rd_ptr;
logic [CNT_W-1:0]	count;
logic			do_push, do_pop;

function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
	if (ptr == PTR_W'(DEPTH - 1)) begin
		return '0;
	end
	return ptr + 1'b1;
endfunction

assign do_push = push_i & ~full_o;
assign do_pop  = pop_i & avail_o;

always_ff @(posedge clk) begin
	if (do_push) begin
		mem[wr_ptr] <= data_i;
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (do_push) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
		if (do_pop) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
		case ({do_push, do_pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;	// both or neither
		endcase
	end
end

assign full_o  = (count == CNT_W'(DEPTH));
assign avail_o = (count != '0);
assign data_o  = mem[rd_ptr];

a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
	push_i |-> !full_o);

a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
	pop_i |-> avail_o);

endmodule

//--- hdl/req_arbiter.sv
`timescale 1ns/1ns

module req_arbiter (
	input  logic                           clk,
	input  logic                           rst_n,

	// write-back source
	input  logic                           wr_req_valid_i,
	input  mem_req_pkg::wr_req_t           wr_req_i,
	output logic                           wr_req_ready_o,

	// read-miss source
	input  logic                           rd_req_valid_i,
	input  logic [mem_req_pkg::ADDR_W-1:0] rd_addr_i,
	output logic                           rd_req_ready_o,

	// request fifo
	input  logic                           req_full_i,
	output logic                           req_push_o,
	output mem_req_pkg::req_t              req_o
);

mem_req_pkg::arb_state_t	state, state_n;
logic				last_wr, last_wr_n;	// write-back won last

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state   <= mem_req_pkg::IDLE;
		last_wr <= 1'b0;
	end else begin
		state   <= state_n;
		last_wr <= last_wr_n;
	end
end

always_comb begin
	state_n   = state;
	last_wr_n = last_wr;

	case (state)
		mem_req_pkg::IDLE: begin
			if (!req_full_i) begin
				if (wr_req_valid_i && (!rd_req_valid_i || !last_wr)) begin
					state_n   = mem_req_pkg::GRANT_WR;
					last_wr_n = 1'b1;
				end else if (rd_req_valid_i) begin
					state_n   = mem_req_pkg::GRANT_RD;
					last_wr_n = 1'b0;
				end
			end
		end
		default: begin
			state_n = mem_req_pkg::IDLE;	// grant is a single cycle
		end
	endcase
end

assign wr_req_ready_o = (state == mem_req_pkg::GRANT_WR);
assign rd_req_ready_o = (state == mem_req_pkg::GRANT_RD);
assign req_push_o     = wr_req_ready_o | rd_req_ready_o;

// fifo entry built from the granted source
always_comb begin
	req_o = '0;
	if (wr_req_ready_o) begin
		req_o.wr   = 1'b1;
		req_o.addr = wr_req_i.addr;
		req_o.data = wr_req_i.data;
	end else if (rd_req_ready_o) begin
		req_o.addr = rd_addr_i;
	end
end

a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
	!(wr_req_ready_o && rd_req_ready_o));

// sources keep valid up from the decision edge through the grant
a_src_held: assert property (@(posedge clk) disable iff (!rst_n)
	(wr_req_ready_o |-> wr_req_valid_i) and (rd_req_ready_o |-> rd_req_valid_i));

endmodule

//--- hdl/axil_req_master.sv
`timescale 1ns/1ns

module axil_req_master (
	input  logic                   clk,
	input  logic                   rst_n,

	// request fifo head
	input  logic                   req_avail_i,
	input  mem_req_pkg::req_t      req_i,
	output logic                   req_pop_o,

	// response fifo
	input  logic                   rsp_full_i,
	output logic                   rsp_push_o,
	output mem_req_pkg::rsp_t      rsp_o,

	output mem_req_pkg::axil_req_t axi_req_o,
	input  mem_req_pkg::axil_rsp_t axi_rsp_i,

	output logic                   wr_err_o
);

typedef enum logic [1:0] {
	S_IDLE,
	S_WRITE,	// aw and w outstanding
	S_WAIT_B,
	S_READ		// ar and r outstanding
} mst_state_t;

mst_state_t				state;

logic					aw_valid, w_valid, b_ready;
logic					ar_valid, r_ready;
logic					rsp_push;
logic					wr_err;

logic [mem_req_pkg::ADDR_W-1:0]	addr_q;
logic [mem_req_pkg::DATA_W-1:0]	data_q;
logic [mem_req_pkg::DATA_W-1:0]	rdata_q;
logic					rerr_q;

logic					issue;
logic					aw_done, w_done, b_hs, r_hs;

// a read needs room, and a push in flight is not yet counted by full
assign issue = (state == S_IDLE) && req_avail_i && (req_i.wr || (!rsp_full_i && !rsp_push));

assign aw_done = !aw_valid || axi_rsp_i.aw_ready;
assign w_done  = !w_valid || axi_rsp_i.w_ready;
assign b_hs    = axi_rsp_i.b_valid & b_ready;
assign r_hs    = axi_rsp_i.r_valid & r_ready;

// ################################################
// transaction control
// ################################################
always_ff @(posedge clk) begin
	if (!rst_n) begin
		state    <= S_IDLE;
		aw_valid <= 1'b0;
		w_valid  <= 1'b0;
		b_ready  <= 1'b0;
		ar_valid <= 1'b0;
		r_ready  <= 1'b0;
		rsp_push <= 1'b0;
		wr_err   <= 1'b0;
	end else begin
		rsp_push <= 1'b0;
		case (state)
			S_IDLE: begin
				if (issue && req_i.wr) begin
					aw_valid <= 1'b1;
					w_valid  <= 1'b1;
					b_ready  <= 1'b1;
					state    <= S_WRITE;
				end else if (issue) begin
					ar_valid <= 1'b1;
					r_ready  <= 1'b1;
					state    <= S_READ;
				end
			end
			S_WRITE: begin
				if (axi_rsp_i.aw_ready) begin
					aw_valid <= 1'b0;
				end
				if (axi_rsp_i.w_ready) begin
					w_valid <= 1'b0;
				end
				if (aw_done && w_done) begin
					state <= S_WAIT_B;
				end
			end
			S_WAIT_B: begin
				if (b_hs) begin
					b_ready <= 1'b0;
					state   <= S_IDLE;
					if (axi_rsp_i.b_resp == mem_req_pkg::RESP_SLVERR) begin
						wr_err <= 1'b1;	// sticky until reset
					end
				end
			end
			S_READ: begin
				if (axi_rsp_i.ar_ready) begin
					ar_valid <= 1'b0;
				end
				if (r_hs) begin
					r_ready  <= 1'b0;
					rsp_push <= 1'b1;
					state    <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (issue) begin
		addr_q <= req_i.addr;
		data_q <= req_i.data;
	end
	if (r_hs) begin
		rdata_q <= axi_rsp_i.r_data;
		rerr_q  <= (axi_rsp_i.r_resp != mem_req_pkg::RESP_OKAY);
	end
end

always_comb begin
	axi_req_o          = '0;
	axi_req_o.aw_valid = aw_valid;
	axi_req_o.aw_addr  = addr_q;
	axi_req_o.w_valid  = w_valid;
	axi_req_o.w_data   = data_q;
	axi_req_o.w_strb   = '1;	// full words only
	axi_req_o.b_ready  = b_ready;
	axi_req_o.ar_valid = ar_valid;
	axi_req_o.ar_addr  = addr_q;
	axi_req_o.r_ready  = r_ready;
end

always_comb begin
	rsp_o      = '0;
	rsp_o.addr = addr_q;
	rsp_o.data = rdata_q;
	rsp_o.err  = rerr_q;
end

assign req_pop_o  = issue;
assign rsp_push_o = rsp_push;
assign wr_err_o   = wr_err;

a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
	axi_req_o.aw_valid && !axi_rsp_i.aw_ready
	|=> axi_req_o.aw_valid && $stable(axi_req_o.aw_addr));

a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
	axi_req_o.ar_valid && !axi_rsp_i.ar_ready
	|=> axi_req_o.ar_valid && $stable(axi_req_o.ar_addr));

endmodule

//--- hdl/mem_req_path.sv
`timescale 1ns/1ns

module mem_req_path #(
	parameter int REQ_DEPTH = 4,
	parameter int RSP_DEPTH = 2
) (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic                           wr_req_valid_i,
	input  mem_req_pkg::wr_req_t           wr_req_i,
	output logic                           wr_req_ready_o,

	input  logic                           rd_req_valid_i,
	input  logic [mem_req_pkg::ADDR_W-1:0] rd_addr_i,
	output logic                           rd_req_ready_o,

	output logic                           rsp_valid_o,
	output mem_req_pkg::rsp_t              rsp_o,
	input  logic                           rsp_ready_i,

	output mem_req_pkg::axil_req_t         axi_req_o,
	input  mem_req_pkg::axil_rsp_t         axi_rsp_i,

	output logic                           wr_err_o
);

mem_req_pkg::req_t	req_in, req_head;
logic			req_push, req_full, req_avail, req_pop;

mem_req_pkg::rsp_t	rsp_in;
logic			rsp_push, rsp_full;
wire			rsp_pop = rsp_valid_o & rsp_ready_i;

req_arbiter arb0 (
	.clk            (clk),
	.rst_n          (rst_n),
	.wr_req_valid_i (wr_req_valid_i),
	.wr_req_i       (wr_req_i),
	.wr_req_ready_o (wr_req_ready_o),
	.rd_req_valid_i (rd_req_valid_i),
	.rd_addr_i      (rd_addr_i),
	.rd_req_ready_o (rd_req_ready_o),
	.req_full_i     (req_full),
	.req_push_o     (req_push),
	.req_o          (req_in)
);

req_fifo #(.payload_t(mem_req_pkg::req_t), .DEPTH(REQ_DEPTH)) req_fifo0 (
	.clk     (clk),
	.rst_n   (rst_n),
	.push_i  (req_push),
	.data_i  (req_in),
	.full_o  (req_full),
	.pop_i   (req_pop),
	.data_o  (req_head),
	.avail_o (req_avail)
);

axil_req_master mst0 (
	.clk         (clk),
	.rst_n       (rst_n),
	.req_avail_i (req_avail),
	.req_i       (req_head),
	.req_pop_o   (req_pop),
	.rsp_full_i  (rsp_full),
	.rsp_push_o  (rsp_push),
	.rsp_o       (rsp_in),
	.axi_req_o   (axi_req_o),
	.axi_rsp_i   (axi_rsp_i),
	.wr_err_o    (wr_err_o)
);

// read data back to the cache, in grant order
req_fifo #(.payload_t(mem_req_pkg::rsp_t), .DEPTH(RSP_DEPTH)) rsp_fifo0 (
	.clk     (clk),
	.rst_n   (rst_n),
	.push_i  (rsp_push),
	.data_i  (rsp_in),
	.full_o  (rsp_full),
	.pop_i   (rsp_pop),
	.data_o  (rsp_o),
	.avail_o (rsp_valid_o)
);

endmodule

//--- bench/axil_mem_model.sv
`timescale 1ns/1ns

module axil_mem_model (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mem_req_pkg::axil_req_t axi_req_i,
	output mem_req_pkg::axil_rsp_t axi_rsp_o
);

logic [31:0]			mem [256];
logic [31:0]			rng;
logic [1:0]			aw_dly, w_dly, ar_dly, b_dly, r_dly;
logic				got_aw, got_w, got_ar;
logic [mem_req_pkg::ADDR_W-1:0]	waddr, raddr;
logic [mem_req_pkg::DATA_W-1:0]	wdata;
mem_req_pkg::axil_rsp_t		rsp_q = '0;

function automatic logic [31:0] next_rand(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

function automatic logic [31:0] fill_word(input logic [7:0] idx);
	return {idx, 8'hd0, ~idx, 8'h3c};
endfunction

initial begin
	for (int i = 0; i < 256; i++) begin
		mem[i] = fill_word(8'(i));
	end
end

assign axi_rsp_o = rsp_q;

always @(posedge clk) begin
	if (!rst_n) begin
		rng                                   <= 32'h5a3c_a3e4;
		{aw_dly, w_dly, ar_dly, b_dly, r_dly} <= 10'h2b5;
		{got_aw, got_w, got_ar}               <= '0;
		rsp_q                                 <= '0;
	end else begin
		rng <= next_rand(rng);

		// ################################################
		// address and data acceptance
		// ################################################
		if (rsp_q.aw_ready) begin
			rsp_q.aw_ready <= 1'b0;
			got_aw         <= 1'b1;
			waddr          <= axi_req_i.aw_addr;
			aw_dly         <= rng[1:0];
		end else if (axi_req_i.aw_valid && !got_aw) begin
			if (aw_dly == 0) begin
				rsp_q.aw_ready <= 1'b1;
			end else begin
				aw_dly <= aw_dly - 1'b1;
			end
		end

		if (rsp_q.w_ready) begin
			rsp_q.w_ready <= 1'b0;
			got_w         <= 1'b1;
			wdata         <= axi_req_i.w_data;
			w_dly         <= rng[3:2];
		end else if (axi_req_i.w_valid && !got_w) begin
			if (w_dly == 0) begin
				rsp_q.w_ready <= 1'b1;
			end else begin
				w_dly <= w_dly - 1'b1;
			end
		end

		if (rsp_q.ar_ready) begin
			rsp_q.ar_ready <= 1'b0;
			got_ar         <= 1'b1;
			raddr          <= axi_req_i.ar_addr;
			ar_dly         <= rng[5:4];
		end else if (axi_req_i.ar_valid && !got_ar) begin
			if (ar_dly == 0) begin
				rsp_q.ar_ready <= 1'b1;
			end else begin
				ar_dly <= ar_dly - 1'b1;
			end
		end

		// ################################################
		// responses
		// ################################################
		if (rsp_q.b_valid) begin
			if (axi_req_i.b_ready) begin
				rsp_q.b_valid <= 1'b0;
				got_aw        <= 1'b0;
				got_w         <= 1'b0;
				b_dly         <= rng[7:6];
			end
		end else if (got_aw && got_w) begin
			if (b_dly != 0) begin
				b_dly <= b_dly - 1'b1;
			end else if (waddr[15]) begin
				rsp_q.b_valid <= 1'b1;
				rsp_q.b_resp  <= mem_req_pkg::RESP_SLVERR;	// error region, write dropped
			end else begin
				rsp_q.b_valid   <= 1'b1;
				rsp_q.b_resp    <= mem_req_pkg::RESP_OKAY;
				mem[waddr[9:2]] <= wdata;
			end
		end

		if (rsp_q.r_valid) begin
			if (axi_req_i.r_ready) begin
				rsp_q.r_valid <= 1'b0;
				got_ar        <= 1'b0;
				r_dly         <= rng[9:8];
			end
		end else if (got_ar) begin
			if (r_dly != 0) begin
				r_dly <= r_dly - 1'b1;
			end else if (raddr[15]) begin
				rsp_q.r_valid <= 1'b1;
				rsp_q.r_data  <= '0;
				rsp_q.r_resp  <= mem_req_pkg::RESP_SLVERR;
			end else begin
				rsp_q.r_valid <= 1'b1;
				rsp_q.r_data  <= mem[raddr[9:2]];
				rsp_q.r_resp  <= mem_req_pkg::RESP_OKAY;
			end
		end
	end
end

endmodule

//--- bench/tb_mem_req_path.sv
`timescale 1ns/1ns

module tb_mem_req_path;

localparam int          WAIT_MAX = 2000;
localparam logic [31:0] SEED     = 32'h5a3c_a3e4;
localparam int          RSP_LOW  = 0;
localparam int          RSP_HIGH = 1;
localparam int          RSP_RAND = 2;

logic				clk;
logic				rst_n;
logic				wr_valid, wr_ready;
mem_req_pkg::wr_req_t		wr_req;
logic				rd_valid, rd_ready;
logic [mem_req_pkg::ADDR_W-1:0]	rd_addr;
logic				rsp_valid, rsp_ready;
mem_req_pkg::rsp_t		rsp, last_rsp;
mem_req_pkg::axil_req_t		axi_req;
mem_req_pkg::axil_rsp_t		axi_rsp;
logic				wr_err;

mem_req_pkg::req_t		grant_q [$];	// granted, not yet replayed
logic				grant_log [$];	// 1 for a write-back grant
logic [31:0]			shadow [256];
logic [31:0]			rng, rdy_rng;
int				rsp_mode;
int				errors, checks, rsp_count, rd_grants, test_errors;

mem_req_path #(.REQ_DEPTH(4), .RSP_DEPTH(2)) dut0 (
	.clk            (clk),
	.rst_n          (rst_n),
	.wr_req_valid_i (wr_valid),
	.wr_req_i       (wr_req),
	.wr_req_ready_o (wr_ready),
	.rd_req_valid_i (rd_valid),
	.rd_addr_i      (rd_addr),
	.rd_req_ready_o (rd_ready),
	.rsp_valid_o    (rsp_valid),
	.rsp_o          (rsp),
	.rsp_ready_i    (rsp_ready),
	.axi_req_o      (axi_req),
	.axi_rsp_i      (axi_rsp),
	.wr_err_o       (wr_err)
);

axil_mem_model mem0 (
	.clk       (clk),
	.rst_n     (rst_n),
	.axi_req_i (axi_req),
	.axi_rsp_o (axi_rsp)
);

always #4 clk = ~clk;

// ################################################
// reference model
// ################################################
function automatic logic [31:0] next_rand(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

function automatic logic [31:0] fill_word(input logic [7:0] idx);
	return {idx, 8'hd0, ~idx, 8'h3c};
endfunction

// replays one granted request on the shadow memory
function automatic mem_req_pkg::rsp_t apply_request(input mem_req_pkg::req_t r);
	mem_req_pkg::rsp_t res;
	res      = '0;
	res.addr = r.addr;
	if (r.addr[15]) begin
		res.err = 1'b1;	// data stays zero
	end else if (r.wr) begin
		shadow[r.addr[9:2]] = r.data;
	end else begin
		res.data = shadow[r.addr[9:2]];
	end
	return res;
endfunction

task automatic compare_value(input string name, input logic [64:0] got, input logic [64:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, exp, got);
		errors++;
	end
endtask

task automatic abort_run(input string why);
	$display("%0t: %s", $time, why);
	$display("FAIL: see errors above");
	$finish;
endtask

task automatic end_test(input int num, input string name);
	if (errors == test_errors) begin
		$display("test %0d %s: ok", num, name);
	end else begin
		$display("test %0d %s: %0d errors", num, name, errors - test_errors);
	end
	test_errors = errors;
endtask

// ################################################
// source drivers, called at a falling edge
// ################################################
task automatic send_write(input logic [31:0] addr, input logic [31:0] data);
	int n;
	wr_valid    = 1'b1;
	wr_req.addr = addr;
	wr_req.data = data;
	n = 0;
	while (!wr_ready && n < WAIT_MAX) begin
		@(negedge clk);
		n++;
	end
	assert (wr_ready) else abort_run("write-back request was never granted");
	@(negedge clk);
	wr_valid = 1'b0;
endtask

task automatic send_read(input logic [31:0] addr);
	int n;
	rd_valid = 1'b1;
	rd_addr  = addr;
	n = 0;
	while (!rd_ready && n < WAIT_MAX) begin
		@(negedge clk);
		n++;
	end
	assert (rd_ready) else abort_run("read-miss request was never granted");
	@(negedge clk);
	rd_valid = 1'b0;
endtask

task automatic wait_responses(input int target);
	int n;
	n = 0;
	while (rsp_count < target && n < WAIT_MAX) begin
		@(negedge clk);
		n++;
	end
	assert (rsp_count >= target) else abort_run("read responses did not arrive in time");
endtask

task automatic set_rsp_mode(input int mode);
	@(posedge clk);
	rsp_mode = mode;
	@(negedge clk);
endtask

always @(negedge clk) begin
	if (rsp_mode == RSP_RAND) begin
		rdy_rng   = next_rand(rdy_rng);
		rsp_ready = rdy_rng[0];
	end else begin
		rsp_ready = (rsp_mode == RSP_HIGH);
	end
end

// grants in the order seen at the ready ports
always @(posedge clk) begin : watch_grants
	mem_req_pkg::req_t g;
	if (rst_n) begin
		assert (!(wr_ready && rd_ready)) else begin
			$display("[ERROR] %0t wr_req_ready_o and rd_req_ready_o high together", $time);
			errors++;
		end
		g = '0;
		if (wr_valid && wr_ready) begin
			g.wr   = 1'b1;
			g.addr = wr_req.addr;
			g.data = wr_req.data;
			grant_q.push_back(g);
			grant_log.push_back(1'b1);
		end
		if (rd_valid && rd_ready) begin
			g.addr = rd_addr;
			grant_q.push_back(g);
			grant_log.push_back(1'b0);
			rd_grants++;
		end
	end
end

// full strobes on every accepted write
always @(posedge clk) begin
	if (rst_n && axi_req.w_valid && axi_rsp.w_ready) begin
		compare_value("w_strb", axi_req.w_strb, 4'hf);
	end
end

always @(posedge clk) begin : check_rsp
	mem_req_pkg::req_t r;
	mem_req_pkg::rsp_t exp;
	logic              found;
	if (rst_n && rsp_valid && rsp_ready) begin
		found = 1'b0;
		exp   = '0;
		while (!found && grant_q.size() != 0) begin
			r     = grant_q.pop_front();
			exp   = apply_request(r);
			found = !r.wr;
		end
		checks++;
		assert (found) else begin
			$display("[ERROR] %0t read response with no read granted before it", $time);
			errors++;
		end
		compare_value("rsp_o", rsp, exp);
		last_rsp = rsp;
		rsp_count++;
	end
end

// ################################################
// test sequence
// ################################################
initial begin
	int          start, base, n;
	logic        expect_wr;
	logic [31:0] r, addr;

	clk       = 1'b0;
	rst_n     = 1'b0;
	wr_valid  = 1'b0;
	wr_req    = '0;
	rd_valid  = 1'b0;
	rd_addr   = '0;
	rsp_ready = 1'b0;
	rsp_mode  = RSP_HIGH;
	rng       = SEED;
	rdy_rng   = SEED ^ 32'hffff_ffff;	// separate stream for rsp_ready
	errors    = 0;
	checks    = 0;
	rsp_count = 0;
	rd_grants = 0;
	test_errors = 0;
	for (int i = 0; i < 256; i++) begin
		shadow[i] = fill_word(8'(i));
	end
	repeat (2) @(negedge clk);
	rst_n = 1'b1;

	compare_value("wr_req_ready_o", wr_ready, 0);
	compare_value("rd_req_ready_o", rd_ready, 0);
	compare_value("rsp_valid_o", rsp_valid, 0);
	compare_value("aw_valid", axi_req.aw_valid, 0);
	compare_value("w_valid", axi_req.w_valid, 0);
	compare_value("ar_valid", axi_req.ar_valid, 0);
	compare_value("b_ready", axi_req.b_ready, 0);
	compare_value("r_ready", axi_req.r_ready, 0);
	compare_value("wr_err_o", wr_err, 0);
	end_test(6, "reset state");

	send_write(32'h0000_0040, 32'hcafe_0123);
	send_read(32'h0000_0040);
	wait_responses(rd_grants);
	compare_value("rsp_o.addr", last_rsp.addr, 32'h0000_0040);
	compare_value("rsp_o.data", last_rsp.data, 32'hcafe_0123);
	compare_value("rsp_o.err", last_rsp.err, 0);
	end_test(1, "write then read");

	start = grant_log.size();
	fork
		begin
			for (int k = 0; k < 8; k++) begin
				send_write(32'h0000_0300 + 4 * k, 32'h2000_0000 + k);
			end
		end
		begin
			for (int k = 0; k < 8; k++) begin
				send_read(32'h0000_0300 + 4 * k);
			end
		end
	join
	wait_responses(rd_grants);
	compare_value("grant count", grant_log.size() - start, 16);
	for (int k = 0; k < 16 && start + k < grant_log.size(); k++) begin
		expect_wr = !grant_log[start + k - 1];	// the other source wins next
		compare_value("grant source", grant_log[start + k], expect_wr);
	end
	end_test(2, "round-robin");

	set_rsp_mode(RSP_LOW);
	base = rsp_count;
	for (int k = 0; k < 6; k++) begin
		send_read(32'h0000_0100 + 4 * k);
	end
	compare_value("rsp_o.addr", rsp.addr, 32'h0000_0100);	// oldest read held at the head
	compare_value("rsp_valid_o", rsp_valid, 1);
	set_rsp_mode(RSP_HIGH);
	wait_responses(base + 6);
	end_test(3, "back-pressure");

	compare_value("wr_err_o", wr_err, 0);
	send_write(32'h0000_8010, 32'hdead_beef);
	n = 0;
	while (!wr_err && n < WAIT_MAX) begin
		@(negedge clk);
		n++;
	end
	assert (wr_err) else abort_run("wr_err_o did not rise after a write to the error region");
	send_read(32'h0000_8010);
	wait_responses(rd_grants);
	compare_value("rsp_o.data", last_rsp.data, 0);
	compare_value("rsp_o.err", last_rsp.err, 1);
	repeat (4) @(negedge clk);
	compare_value("wr_err_o", wr_err, 1);
	end_test(4, "error region");

	set_rsp_mode(RSP_RAND);
	for (int k = 0; k < 200; k++) begin
		rng  = next_rand(rng);
		r    = rng;
		addr = 32'h0000_0200 + {r[3:0], 2'b00};	// 16 words
		if (r[4]) begin
			send_write(addr, {r[31:8], 8'(k)});
		end else begin
			send_read(addr);
		end
		repeat (r[6:5]) @(negedge clk);
	end
	set_rsp_mode(RSP_HIGH);
	wait_responses(rd_grants);
	repeat (8) @(negedge clk);
	compare_value("response count", rsp_count, rd_grants);
	compare_value("wr_err_o", wr_err, 1);
	end_test(5, "random mix");

	$display("tests 6, checks %0d, errors %0d, responses %0d", checks, errors, rsp_count);
	if (errors == 0) begin
		$display("PASS: all tests");
	end else begin
		$display("FAIL: see errors above");
	end
	$finish;
end

endmodule

//--- sources.f
hdl/mem_req_pkg.sv
hdl/req_fifo.sv
hdl/req_arbiter.sv
hdl/axil_req_master.sv
hdl/mem_req_path.sv
bench/axil_mem_model.sv
bench/tb_mem_req_path.sv

//--- Bender.yml
package:
  name: mem_req_path

sources:
  - hdl/mem_req_pkg.sv
  - hdl/req_fifo.sv
  - hdl/req_arbiter.sv
  - hdl/axil_req_master.sv
  - hdl/mem_req_path.sv
  - target: test
    files:
      - bench/axil_mem_model.sv
      - bench/tb_mem_req_path.sv
